/* design/cache_array.sv */
// cache data and tag arrays, hit test, write-allocate and miss refill
`timescale 1ns/1ps
`include "vmem_cache_defs.svh"

module cache_array
(
  input  logic                    CPU_CLK,
  input  logic                    RST,
  input  vmem_cache_pkg::lookup_t  lookup,
  output vmem_cache_pkg::mem_req_t miss_req,
  input  logic                    miss_ready,
  input  vmem_cache_pkg::mem_rsp_t refill,
  output vmem_cache_pkg::cpu_rsp_t cpu_rsp,
  output logic                    done
);

  import vmem_cache_pkg::*;

  typedef enum logic [1:0] {st_idle, st_send, st_refill} state_t;

  logic [31:0]          data_mem [`VC_LINES];
  logic [`VC_CTAG_W-1:0] tag_mem [`VC_LINES];
  logic [`VC_LINES-1:0] line_vld;

  state_t                state, state_nxt;
  lookup_t               s2;
  logic                  s2_v;
  logic [31:0]           rd_data;
  logic [`VC_CTAG_W-1:0] rd_tag;
  logic                  rd_vld;
  logic [`VC_IDX_MSB-`VC_IDX_LSB:0] rd_idx, wr_idx;
  logic [`VC_CTAG_W-1:0] ctag;
  logic                  hit, need_mem, idle_req;
  logic                  arr_we;
  logic                  rsp_set, rsp_fault_d;
  logic [31:0]           rsp_data_d;
  logic                  rsp_v, rsp_fault;
  logic [31:0]           rsp_data;

  assign rd_idx = lookup.paddr[`VC_IDX_MSB:`VC_IDX_LSB];
  assign wr_idx = s2.paddr[`VC_IDX_MSB:`VC_IDX_LSB];
  assign ctag   = s2.paddr[31:`VC_IDX_MSB+1];

  // ----------------------------------------------------------------------
  // array read stage
  // ----------------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    rd_data <= data_mem[rd_idx];
    rd_tag  <= tag_mem[rd_idx];
    rd_vld  <= line_vld[rd_idx];
    if (lookup.valid)
      s2 <= lookup;
  end

  // inhibit never hits
  assign hit      = rd_vld & (rd_tag == ctag) & ~s2.inhibit;
  assign idle_req = (state == st_idle) & s2_v;
  assign need_mem = ~s2.tlb_wr & ~s2.fault & (s2.we | ~hit);

  always_comb
  begin
    miss_req.valid = (idle_req & need_mem) | (state == st_send);
    miss_req.we    = s2.we;
    miss_req.addr  = s2.paddr[31:2];
    miss_req.data  = s2.data;
  end

  // write-allocate on cpu writes, fill on refill, never when inhibited
  assign arr_we = ~s2.inhibit &
                  ((idle_req & s2.we & ~s2.fault & ~s2.tlb_wr) |
                   ((state == st_refill) & refill.valid));

  // ----------------------------------------------------------------------
  // request completion
  // ----------------------------------------------------------------------
  always_comb
  begin
    state_nxt   = state;
    done        = 1'b0;
    rsp_set     = 1'b0;
    rsp_fault_d = 1'b0;
    rsp_data_d  = rd_data;
    case (state)
      st_idle:
      begin
        if (s2_v)
        begin
          if (s2.tlb_wr)
            done = 1'b1;
          else if (s2.fault)
          begin
            done        = 1'b1;
            rsp_set     = 1'b1;
            rsp_fault_d = 1'b1;
          end
          else if (s2.we)
          begin
            if (miss_ready)
              done = 1'b1;
            else
              state_nxt = st_send;
          end
          else if (hit)
          begin
            done    = 1'b1;
            rsp_set = 1'b1;
          end
          else
            state_nxt = miss_ready ? st_refill : st_send;
        end
      end
      st_send:
      begin
        if (miss_ready)
        begin
          done      = s2.we;
          state_nxt = s2.we ? st_idle : st_refill;
        end
      end
      default:
      begin
        if (refill.valid)
        begin
          done       = 1'b1;
          rsp_set    = 1'b1;
          rsp_data_d = refill.data;
          state_nxt  = st_idle;
        end
      end
    endcase
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state    <= st_idle;
      s2_v     <= 1'b0;
      rsp_v    <= 1'b0;
      line_vld <= '0;
    end
    else
    begin
      state <= state_nxt;
      s2_v  <= lookup.valid;
      rsp_v <= rsp_set;
      if (arr_we)
        line_vld[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (arr_we)
    begin
      data_mem[wr_idx] <= s2.we ? s2.data : refill.data;
      tag_mem[wr_idx]  <= ctag;
    end
    if (rsp_set)
    begin
      rsp_fault <= rsp_fault_d;
      rsp_data  <= rsp_data_d;
    end
  end

  always_comb
  begin
    cpu_rsp.valid = rsp_v;
    cpu_rsp.fault = rsp_fault;
    cpu_rsp.data  = rsp_data;
  end

endmodule

/* design/cpu_port.sv */
// cpu request acceptance, request register and ready handling
`timescale 1ns/1ps

module cpu_port
(
  input  logic                    CPU_CLK,
  input  logic                    RST,
  input  vmem_cache_pkg::cpu_req_t cpu_req,
  input  logic                    vmem_act,
  output logic                    cpu_ready,
  input  logic                    done,
  output vmem_cache_pkg::cpu_req_t lookup_req,
  output logic                    vmem
);

  import vmem_cache_pkg::*;

  cpu_req_t req_q;
  logic     req_v;
  logic     busy;
  logic     vmem_q;
  logic     accept;

  // one request in flight, ready drops on acceptance
  assign cpu_ready = ~busy;
  assign accept    = cpu_req.valid & cpu_ready;

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      busy  <= 1'b0;
      req_v <= 1'b0;
    end
    else
    begin
      req_v <= accept;
      if (accept)
        busy <= 1'b1;
      else if (done)
        busy <= 1'b0;
    end
  end

  // payload and the vmem level, sampled once per request
  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
    begin
      req_q  <= cpu_req;
      vmem_q <= vmem_act;
    end
  end

  // valid is a single cycle pulse into the tlb stage
  always_comb
  begin
    lookup_req       = req_q;
    lookup_req.valid = req_v;
  end

  assign vmem = vmem_q;

endmodule

/* design/mem_request.sv */
// memory request holding register, credit counter and refill return
`timescale 1ns/1ps
`include "vmem_cache_defs.svh"

module mem_request
(
  input  logic                    CPU_CLK,
  input  logic                    RST,
  input  vmem_cache_pkg::mem_req_t miss_req,
  output logic                    miss_ready,
  output vmem_cache_pkg::mem_rsp_t refill,
  output vmem_cache_pkg::mem_req_t mem_req,
  input  logic                    mem_credit,
  input  vmem_cache_pkg::mem_rsp_t mem_rsp
);

  import vmem_cache_pkg::*;

  localparam int CRED_W = $clog2(`VC_MEM_CREDITS + 1);

  mem_req_t          hold;
  logic              hold_v;
  logic [CRED_W-1:0] credits;
  logic              rd_pend;
  logic              send;

  // one entry, refilled only once it has gone out
  assign miss_ready = ~hold_v;
  // no credit, no send
  assign send       = hold_v & (credits != '0);

  always_ff @(posedge CPU_CLK)
  begin
    if (miss_req.valid && miss_ready)
      hold <= miss_req;
  end

  // ----------------------------------------------------------------------
  // holding register and outstanding read
  // ----------------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      hold_v  <= 1'b0;
      rd_pend <= 1'b0;
    end
    else
    begin
      if (miss_req.valid && miss_ready)
        hold_v <= 1'b1;
      else if (send)
        hold_v <= 1'b0;

      if (send && !hold.we)
        rd_pend <= 1'b1;
      else if (mem_rsp.valid)
        rd_pend <= 1'b0;
    end
  end

  // ----------------------------------------------------------------------
  // credit counter
  // ----------------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
      credits <= CRED_W'(`VC_MEM_CREDITS);
    else
    begin
      case ({send, mem_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_comb
  begin
    mem_req       = hold;
    mem_req.valid = send;
  end

  // stray read data is dropped
  always_comb
  begin
    refill.valid = mem_rsp.valid & rd_pend;
    refill.data  = mem_rsp.data;
  end

endmodule

/* design/tlb_translate.sv */
// tlb arrays, virtual to physical translation and fault detection
`timescale 1ns/1ps
`include "vmem_cache_defs.svh"

module tlb_translate
(
  input  logic                    CPU_CLK,
  input  logic                    RST,
  input  vmem_cache_pkg::cpu_req_t lookup_req,
  input  logic                    vmem,
  output vmem_cache_pkg::lookup_t  lookup
);

  import vmem_cache_pkg::*;

  tlb_entry_t tlb_mem [`VC_TLB_ENTRIES];

  tlb_entry_t                     entry_q;
  cpu_req_t                       req_q;
  logic                           v_q;
  logic                           vmem_q;
  logic [`VC_TLB_MSB-`VC_TLB_LSB:0] tlb_idx;
  logic [`VC_VTAG_W-1:0]          vtag;
  logic [31:0]                    phys_addr;
  logic                           tag_miss;

  assign tlb_idx = lookup_req.addr[`VC_TLB_MSB:`VC_TLB_LSB];

  // ----------------------------------------------------------------------
  // tlb storage, synchronous read
  // ----------------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (lookup_req.valid && lookup_req.tlb_we)
      tlb_mem[tlb_idx] <= lookup_req.wdata.tlb;
    entry_q <= tlb_mem[tlb_idx];
    req_q   <= lookup_req;
    vmem_q  <= vmem;
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
      v_q <= 1'b0;
    else
      v_q <= lookup_req.valid;
  end

  // ----------------------------------------------------------------------
  // translation
  // ----------------------------------------------------------------------
  assign vtag      = req_q.addr[31:`VC_TLB_MSB+1];
  assign phys_addr = {entry_q.ptag[`VC_VTAG_W-1:0], req_q.addr[`VC_TLB_MSB:0]};
  assign tag_miss  = entry_q.vtag[`VC_VTAG_W-1:0] != vtag;

  always_comb
  begin
    lookup.valid   = v_q;
    // identity mapping while virtual memory is off
    lookup.paddr   = vmem_q ? phys_addr : req_q.addr;
    lookup.we      = req_q.we;
    lookup.inhibit = req_q.inhibit;
    lookup.data    = req_q.wdata.word;
    lookup.fault   = vmem_q & ~req_q.tlb_we & tag_miss;
    // tlb write only releases the port
    lookup.tlb_wr  = req_q.tlb_we;
  end

endmodule

/* design/vmem_cache_pkg.sv */
// request, response, memory channel and tlb entry types for the cache
package vmem_cache_pkg;

  // one tlb entry, low 14 bits of each tag are used
  typedef struct packed {
    logic [15:0] ptag;
    logic [15:0] vtag;
  } tlb_entry_t;

  // cpu write word, store data or a tlb entry
  typedef union packed {
    logic [31:0] word;
    tlb_entry_t  tlb;
  } cpu_wdata_u;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic        we;
    logic        tlb_we;
    logic        inhibit;
    cpu_wdata_u  wdata;
  } cpu_req_t;

  typedef struct packed {
    logic        valid;
    logic        fault;
    logic [31:0] data;
  } cpu_rsp_t;

  // translated request into the cache arrays
  typedef struct packed {
    logic        valid;
    logic [31:0] paddr;
    logic        we;
    logic        inhibit;
    logic [31:0] data;
    logic        fault;
    logic        tlb_wr;
  } lookup_t;

  // word addressed memory channel
  typedef struct packed {
    logic        valid;
    logic        we;
    logic [29:0] addr;
    logic [31:0] data;
  } mem_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] data;
  } mem_rsp_t;

endpackage

/* design/vmem_cache_top.sv */
// top level of the virtually addressed write-through cache
`timescale 1ns/1ps

module vmem_cache_top
(
  input  logic                    CPU_CLK,
  input  logic                    RST,
  input  vmem_cache_pkg::cpu_req_t cpu_req,
  input  logic                    vmem_act,
  output logic                    cpu_ready,
  output vmem_cache_pkg::cpu_rsp_t cpu_rsp,
  output vmem_cache_pkg::mem_req_t mem_req,
  input  logic                    mem_credit,
  input  vmem_cache_pkg::mem_rsp_t mem_rsp
);

  import vmem_cache_pkg::*;

  cpu_req_t lookup_req;
  lookup_t  lookup;
  mem_req_t miss_req;
  mem_rsp_t refill;
  logic     vmem;
  logic     done;
  logic     miss_ready;

  // input side
  cpu_port u_cpu_port
  (
    .CPU_CLK    (CPU_CLK),
    .RST        (RST),
    .cpu_req    (cpu_req),
    .vmem_act   (vmem_act),
    .cpu_ready  (cpu_ready),
    .done       (done),
    .lookup_req (lookup_req),
    .vmem       (vmem)
  );

  tlb_translate u_tlb_translate
  (
    .CPU_CLK    (CPU_CLK),
    .RST        (RST),
    .lookup_req (lookup_req),
    .vmem       (vmem),
    .lookup     (lookup)
  );

  cache_array u_cache_array
  (
    .CPU_CLK    (CPU_CLK),
    .RST        (RST),
    .lookup     (lookup),
    .miss_req   (miss_req),
    .miss_ready (miss_ready),
    .refill     (refill),
    .cpu_rsp    (cpu_rsp),
    .done       (done)
  );

  // output side toward main memory
  mem_request u_mem_request
  (
    .CPU_CLK    (CPU_CLK),
    .RST        (RST),
    .miss_req   (miss_req),
    .miss_ready (miss_ready),
    .refill     (refill),
    .mem_req    (mem_req),
    .mem_credit (mem_credit),
    .mem_rsp    (mem_rsp)
  );

endmodule

/* include/vmem_cache_defs.svh */
// address split, array depths and memory credit count for the cache
`ifndef VMEM_CACHE_DEFS_SVH
`define VMEM_CACHE_DEFS_SVH

// ----------------------------------------------------------------------
// address split
// ----------------------------------------------------------------------
// cache line index
`define VC_IDX_LSB 2
`define VC_IDX_MSB 9
// tlb entry index
`define VC_TLB_LSB 10
`define VC_TLB_MSB 17
// virtual page tag, address bits 31 to 18
`define VC_VTAG_W 14
// cache tag, physical address bits 31 to 10
`define VC_CTAG_W 22

// ----------------------------------------------------------------------
// array depths and flow control
// ----------------------------------------------------------------------
`define VC_LINES 256
`define VC_TLB_ENTRIES 256
`define VC_MEM_CREDITS 4

`endif

/* sim/tb_vmem_cache.sv */
// testbench top with clock, reset, memory model, lfsr stimulus, reference model and timeout
`timescale 1ns/1ps
`include "vmem_cache_defs.svh"

module tb_vmem_cache;

  import vmem_cache_pkg::*;

  typedef struct packed {
    cpu_rsp_t rsp;
    mem_req_t mem;
  } expect_t;

  localparam logic [31:0] SEED           = 32'heb42;
  localparam int          NUM_TESTS      = 6;
  localparam int          RAND_REQS      = 200;
  localparam int          TOTAL_REQS     = 2 + 2 + 2 + 1 + 5 + 4 + RAND_REQS;
  localparam int          TIMEOUT_CYCLES = 200 * TOTAL_REQS;
  localparam int          DRAIN_CYCLES   = 200;

  logic       CPU_CLK = 1'b0;
  logic       RST;
  cpu_req_t   cpu_req;
  logic       vmem_act;
  logic       cpu_ready;
  cpu_rsp_t   cpu_rsp;
  mem_req_t   mem_req;
  logic       mem_credit = 1'b0;
  mem_rsp_t   mem_rsp = '0;

  logic       exp_push;
  cpu_rsp_t   exp_rsp;
  mem_req_t   exp_mem;
  logic       test_end;
  logic [3:0] test_num;
  int         pending;
  int         err_total;
  int         tests_failed;

  logic [31:0] stim_lfsr;
  logic [31:0] mem_lfsr;
  int          run_cycles;

  // reference state
  tlb_entry_t          ref_tlb [`VC_TLB_ENTRIES];
  logic [`VC_LINES-1:0] ref_line_v = '0;
  logic [21:0]         ref_line_tag [`VC_LINES];
  logic [31:0]         ref_line_data [`VC_LINES];
  logic [31:0]         ref_mem [logic [29:0]];

  // memory model state
  logic [31:0] mem_store [logic [29:0]];
  int          credit_due [$];
  int          rd_due [$];
  logic [31:0] rd_word [$];
  int          mem_cycle;
  int          last_credit;
  int          last_rd;
  logic [31:0] dly;

  always #4 CPU_CLK = ~CPU_CLK;

  vmem_cache_top UUT
  (
    .CPU_CLK    (CPU_CLK),
    .RST        (RST),
    .cpu_req    (cpu_req),
    .vmem_act   (vmem_act),
    .cpu_ready  (cpu_ready),
    .cpu_rsp    (cpu_rsp),
    .mem_req    (mem_req),
    .mem_credit (mem_credit),
    .mem_rsp    (mem_rsp)
  );

  vmem_cache_checker u_checker
  (
    .CPU_CLK      (CPU_CLK),
    .RST          (RST),
    .cpu_ready    (cpu_ready),
    .cpu_rsp      (cpu_rsp),
    .mem_req      (mem_req),
    .mem_credit   (mem_credit),
    .exp_push     (exp_push),
    .exp_rsp      (exp_rsp),
    .exp_mem      (exp_mem),
    .test_end     (test_end),
    .test_num     (test_num),
    .pending      (pending),
    .err_total    (err_total),
    .tests_failed (tests_failed)
  );

  // ----------------------------------------------------------------------
  // galois lfsr random source stepped once per bit
  // ----------------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic take_bits(inout logic [31:0] state, input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v     = {v[30:0], state[0]};
      state = lfsr_next(state);
    end
  endtask

  // memory contents before any write
  function automatic logic [31:0] initial_word(input logic [29:0] waddr);
    initial_word = {2'b00, waddr} ^ 32'h5a5a0000;
  endfunction

  // ----------------------------------------------------------------------
  // reference model of tlb, cache lines and memory
  // ----------------------------------------------------------------------
  function automatic void fill_line(input logic [7:0] li, input logic [21:0] tag,
                                    input logic [31:0] data);
    ref_line_v[li]    = 1'b1;
    ref_line_tag[li]  = tag;
    ref_line_data[li] = data;
  endfunction

  function automatic expect_t ref_access(input cpu_req_t r, input logic vm);
    expect_t     e;
    tlb_entry_t  ent;
    logic [31:0] pa;
    logic [7:0]  li;
    logic [21:0] ctag;
    e   = '0;
    ent = ref_tlb[r.addr[17:10]];
    if (r.tlb_we)
      ref_tlb[r.addr[17:10]] = r.wdata.tlb;
    else if (vm && ent.vtag[13:0] != r.addr[31:18])
    begin
      e.rsp.valid = 1'b1;
      e.rsp.fault = 1'b1;
    end
    else
    begin
      pa         = vm ? {ent.ptag[13:0], r.addr[17:0]} : r.addr;
      li         = pa[9:2];
      ctag       = pa[31:10];
      e.mem.addr = pa[31:2];
      if (r.we)
      begin
        e.mem.valid       = 1'b1;
        e.mem.we          = 1'b1;
        e.mem.data        = r.wdata.word;
        ref_mem[pa[31:2]] = r.wdata.word;
        if (!r.inhibit)
          fill_line(li, ctag, r.wdata.word);
      end
      else
      begin
        e.rsp.valid = 1'b1;
        if (!r.inhibit && ref_line_v[li] && ref_line_tag[li] == ctag)
          e.rsp.data = ref_line_data[li];
        else
        begin
          e.mem.valid = 1'b1;
          e.rsp.data  = ref_mem.exists(pa[31:2]) ? ref_mem[pa[31:2]] : initial_word(pa[31:2]);
          if (!r.inhibit)
            fill_line(li, ctag, e.rsp.data);
        end
      end
    end
    ref_access = e;
  endfunction

  // ----------------------------------------------------------------------
  // memory model returns credits and read data after 1 to 6 cycles
  // ----------------------------------------------------------------------
  always @(negedge CPU_CLK)
  begin
    mem_cycle  = mem_cycle + 1;
    mem_credit = 1'b0;
    mem_rsp    = '0;
    if (credit_due.size() > 0 && credit_due[0] <= mem_cycle)
    begin
      credit_due.delete(0);
      mem_credit = 1'b1;
    end
    if (rd_due.size() > 0 && rd_due[0] <= mem_cycle)
    begin
      rd_due.delete(0);
      mem_rsp.valid = 1'b1;
      mem_rsp.data  = rd_word.pop_front();
    end
    // a valid request here is taken on the next rising edge
    if (RST === 1'b1 && mem_req.valid === 1'b1)
    begin
      take_bits(mem_lfsr, 3, dly);
      last_credit = (mem_cycle + int'(dly % 6) + 1 > last_credit) ?
                    mem_cycle + int'(dly % 6) + 1 : last_credit + 1;
      credit_due.push_back(last_credit);
      if (mem_req.we)
        mem_store[mem_req.addr] = mem_req.data;
      else
      begin
        take_bits(mem_lfsr, 3, dly);
        last_rd = (mem_cycle + int'(dly % 6) + 1 > last_rd) ?
                  mem_cycle + int'(dly % 6) + 1 : last_rd + 1;
        rd_due.push_back(last_rd);
        rd_word.push_back(mem_store.exists(mem_req.addr) ? mem_store[mem_req.addr] :
                          initial_word(mem_req.addr));
      end
    end
  end

  always @(posedge CPU_CLK)
  begin
    run_cycles = run_cycles + 1;
    if (run_cycles >= TIMEOUT_CYCLES)
    begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // stimulus driven on the falling edge
  // ----------------------------------------------------------------------
  task automatic issue(input logic [31:0] addr, input logic we, input logic tlb_we,
                       input logic inh, input logic [31:0] wd, input logic vm);
    cpu_req_t r;
    expect_t  e;
    while (cpu_ready !== 1'b1)
      @(negedge CPU_CLK);
    r.valid      = 1'b1;
    r.addr       = addr;
    r.we         = we;
    r.tlb_we     = tlb_we;
    r.inhibit    = inh;
    r.wdata.word = wd;
    e            = ref_access(r, vm);
    cpu_req      = r;
    vmem_act     = vm;
    exp_rsp      = e.rsp;
    exp_mem      = e.mem;
    exp_push     = 1'b1;
    @(negedge CPU_CLK);
    cpu_req.valid = 1'b0;
    exp_push      = 1'b0;
  endtask

  task automatic end_test(input int n);
    int waited;
    waited = 0;
    while ((pending != 0 || cpu_ready !== 1'b1) && waited < DRAIN_CYCLES)
    begin
      @(negedge CPU_CLK);
      waited = waited + 1;
    end
    test_num = 4'(n);
    test_end = 1'b1;
    @(negedge CPU_CLK);
    test_end = 1'b0;
  endtask

  task automatic random_traffic(input int count);
    logic [31:0] op;
    logic [31:0] vm;
    logic [31:0] ti;
    logic [31:0] bad;
    logic [31:0] li;
    logic [31:0] wd;
    logic [13:0] vtag;
    // four tlb entries for the random address range
    for (int k = 0; k < 4; k++)
      issue({14'h0000, 8'(k), 10'h000}, 1'b0, 1'b1, 1'b0,
            {16'h0200 + 16'(k), 16'h0100 + 16'(k)}, 1'b1);
    for (int n = 0; n < count; n++)
    begin
      take_bits(stim_lfsr, 3, op);
      take_bits(stim_lfsr, 1, vm);
      take_bits(stim_lfsr, 2, ti);
      take_bits(stim_lfsr, 1, bad);
      take_bits(stim_lfsr, 4, li);
      take_bits(stim_lfsr, 32, wd);
      // bad tag gives a fault with vmem on
      vtag = 14'h0100 + 14'(ti[1:0]) + (bad[0] ? 14'd4 : 14'd0);
      issue({vtag, 6'b000000, ti[1:0], 4'b0000, li[3:0], 2'b00},
            (op[2:1] == 2'b10) | (op[2:0] == 3'd7), 1'b0, op[2:1] == 2'b11, wd, vm[0]);
    end
  endtask

  initial
  begin
    RST         = 1'b0;
    cpu_req     = '0;
    vmem_act    = 1'b0;
    exp_push    = 1'b0;
    exp_rsp     = '0;
    exp_mem     = '0;
    test_end    = 1'b0;
    test_num    = '0;
    stim_lfsr   = SEED;
    mem_lfsr    = SEED;
    run_cycles  = 0;
    mem_cycle   = 0;
    last_credit = 0;
    last_rd     = 0;
    repeat (16) @(negedge CPU_CLK);
    RST = 1'b1;
    @(negedge CPU_CLK);

    // read miss then hit with identity mapping
    issue(32'h0000_1230, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0);
    issue(32'h0000_1230, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0);
    end_test(1);
    // write-through and write-allocate
    issue(32'h0004_0568, 1'b1, 1'b0, 1'b0, 32'hc0ffee01, 1'b0);
    issue(32'h0004_0568, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0);
    end_test(2);
    // translated read after a tlb write
    issue({14'h0a5c, 8'h21, 10'h000}, 1'b0, 1'b1, 1'b0, {16'h0123, 16'h0a5c}, 1'b1);
    issue({14'h0a5c, 8'h21, 10'h0f4}, 1'b0, 1'b0, 1'b0, 32'h0, 1'b1);
    end_test(3);
    // tag mismatch
    issue({14'h0a5d, 8'h21, 10'h0f4}, 1'b0, 1'b0, 1'b0, 32'h0, 1'b1);
    end_test(4);
    // cache-inhibit bypass
    issue(32'h0008_0a40, 1'b0, 1'b0, 1'b1, 32'h0, 1'b0);
    issue(32'h0008_0a40, 1'b0, 1'b0, 1'b1, 32'h0, 1'b0);
    issue(32'h0008_0a40, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0);
    issue(32'h0008_0a40, 1'b1, 1'b0, 1'b1, 32'h13579bdf, 1'b0);
    issue(32'h0008_0a40, 1'b0, 1'b0, 1'b0, 32'h0, 1'b0);
    end_test(5);
    random_traffic(RAND_REQS);
    end_test(6);

    repeat (2) @(negedge CPU_CLK);
    $display("%0d of %0d tests passed, %0d errors", NUM_TESTS - tests_failed, NUM_TESTS,
             err_total);
    if (tests_failed == 0 && err_total == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* sim/vmem_cache_checker.sv */
// response, timing and memory traffic checker with credit watch and per-test report
`timescale 1ns/1ps
`include "vmem_cache_defs.svh"

module vmem_cache_checker
(
  input  logic                     CPU_CLK,
  input  logic                     RST,
  input  logic                     cpu_ready,
  input  vmem_cache_pkg::cpu_rsp_t cpu_rsp,
  input  vmem_cache_pkg::mem_req_t mem_req,
  input  logic                     mem_credit,
  input  logic                     exp_push,
  input  vmem_cache_pkg::cpu_rsp_t exp_rsp,
  input  vmem_cache_pkg::mem_req_t exp_mem,
  input  logic                     test_end,
  input  logic [3:0]               test_num,
  output int                       pending,
  output int                       err_total,
  output int                       tests_failed
);

  import vmem_cache_pkg::*;

  cpu_rsp_t rsp_q [$];
  mem_req_t mem_q [$];
  int       test_errs;
  int       in_flight;
  int       age = -1;
  logic     fixed_lat;
  logic     rsp_due;

  task automatic count_error();
    test_errs = test_errs + 1;
    err_total = err_total + 1;
  endtask

  task automatic report_value(input string sig, input logic [31:0] exp, input logic [31:0] act);
    $display("ERROR %s expected %h got %h", sig, exp, act);
    count_error();
  endtask

  task automatic check_rsp();
    cpu_rsp_t e;
    if (rsp_q.size() == 0)
    begin
      $display("a cpu response arrived while no response was expected");
      count_error();
    end
    else
    begin
      e = rsp_q.pop_front();
      if (cpu_rsp.fault !== e.fault)
        report_value("cpu_rsp.fault", {31'b0, e.fault}, {31'b0, cpu_rsp.fault});
      else if (!e.fault && cpu_rsp.data !== e.data)
        report_value("cpu_rsp.data", e.data, cpu_rsp.data);
    end
  endtask

  task automatic check_mem();
    mem_req_t e;
    if (mem_q.size() == 0)
    begin
      $display("a memory request went out although none was expected");
      count_error();
    end
    else
    begin
      e = mem_q.pop_front();
      if (mem_req.we !== e.we)
        report_value("mem_req.we", {31'b0, e.we}, {31'b0, mem_req.we});
      if (mem_req.addr !== e.addr)
        report_value("mem_req.addr", {2'b00, e.addr}, {2'b00, mem_req.addr});
      // read requests carry no meaningful data
      if (e.we && mem_req.data !== e.data)
        report_value("mem_req.data", e.data, mem_req.data);
    end
  endtask

  // ----------------------------------------------------------------------
  // completion timing of the request in flight
  // ----------------------------------------------------------------------
  task automatic check_timing();
    if (age >= 0)
    begin
      age = age + 1;
      if (age < 4 && cpu_ready === 1'b1)
      begin
        $display("cpu_ready came back %0d cycles after acceptance, too early", age);
        count_error();
      end
      if (age == 4 && fixed_lat)
      begin
        if (cpu_ready !== 1'b1)
        begin
          $display("cpu_ready stayed low 3 cycles after a request with fixed latency");
          count_error();
        end
        if (rsp_due && cpu_rsp.valid !== 1'b1)
        begin
          $display("the cpu response did not come 3 cycles after acceptance");
          count_error();
        end
      end
      if (age >= 4 && cpu_ready === 1'b1)
        age = -1;
    end
  endtask

  task automatic close_test();
    if (rsp_q.size() != 0 || mem_q.size() != 0)
    begin
      $display("test %0d: %0d cpu responses and %0d memory requests never arrived",
               test_num, rsp_q.size(), mem_q.size());
      count_error();
      rsp_q.delete();
      mem_q.delete();
    end
    if (test_errs == 0)
      $display("test %0d passed", test_num);
    else
    begin
      $display("test %0d failed with %0d errors", test_num, test_errs);
      tests_failed = tests_failed + 1;
    end
    test_errs = 0;
  endtask

  // ----------------------------------------------------------------------
  // sampled on the rising edge before the dut updates
  // ----------------------------------------------------------------------
  always @(posedge CPU_CLK)
  begin
    if (RST !== 1'b1)
    begin
      rsp_q.delete();
      mem_q.delete();
      in_flight = 0;
      age       = -1;
    end
    else
    begin
      if (exp_push === 1'b1)
      begin
        if (exp_rsp.valid)
          rsp_q.push_back(exp_rsp);
        if (exp_mem.valid)
          mem_q.push_back(exp_mem);
      end
      if (cpu_rsp.valid === 1'b1)
        check_rsp();
      if (mem_req.valid === 1'b1)
        check_mem();
      check_timing();
      // a new request starts its latency count
      if (exp_push === 1'b1 && cpu_ready === 1'b1)
      begin
        age       = 0;
        rsp_due   = exp_rsp.valid;
        fixed_lat = exp_mem.valid ? (exp_mem.we && in_flight < `VC_MEM_CREDITS) : 1'b1;
      end
      // requests sent minus credits returned
      if (mem_req.valid === 1'b1)
        in_flight = in_flight + 1;
      if (mem_credit === 1'b1)
        in_flight = in_flight - 1;
      if (in_flight > `VC_MEM_CREDITS)
      begin
        $display("credit overrun: %0d memory requests sent without a returned credit",
                 in_flight);
        count_error();
      end
      if (test_end === 1'b1)
        close_test();
    end
    pending = rsp_q.size() + mem_q.size();
  end

endmodule

/* vmem_cache.f */
+incdir+include
design/vmem_cache_pkg.sv
design/cpu_port.sv
design/tlb_translate.sv
design/cache_array.sv
design/mem_request.sv
design/vmem_cache_top.sv
sim/vmem_cache_checker.sv
sim/tb_vmem_cache.sv
